// ==== build.f ====
+incdir+logic
+incdir+dv
logic/aznable_pkg.sv
logic/bus_decoder.sv
logic/system_control.sv
logic/ms_timer.sv
logic/input_ports.sv
logic/memory_block.sv
logic/aznable_bus.sv
dv/aznable_bus_tb.sv

// ==== dv/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int pass_count = 0;
int fail_count = 0;

// One line per finished check
task automatic check_data(input string name, input bus_data_t expected, input bus_data_t actual);
	if (actual === expected)
	begin
		pass_count++;
		$display("PASS   %s", name);
	end
	else
	begin
		fail_count++;
		$display("[ERROR] %s expected %h actual %h", name, expected, actual);
	end
endtask

task automatic check_timer(input string name, input timer_t expected, input timer_t actual);
	if (actual === expected)
	begin
		pass_count++;
		$display("PASS   %s", name);
	end
	else
	begin
		fail_count++;
		$display("[ERROR] %s expected %h actual %h", name, expected, actual);
	end
endtask

// Failures that have no expected value, such as a missing or early ack
task automatic report_failure(input string what);
	fail_count++;
	$display("FAILED %s", what);
endtask

task automatic print_summary();
	$display("Checks passed %0d, failed %0d", pass_count, fail_count);
endtask

`endif

// ==== dv/aznable_bus_tb.sv ====
`timescale 1ns/1ps
`include "aznable_settings.svh"

module aznable_bus_tb;
	import aznable_pkg::*;

	`include "tb_checks.svh"

	logic			clk_24;
	logic			reset;
	wb_req_t		wb_req;
	logic			ack;
	bus_data_t		dat_r;
	download_t		download;
	player_inputs_t	inputs;
	logic			pause;

	logic [31:0]	lfsr = 32'h983b;
	bus_data_t		rom_model [0:(1 << `ROM_WIDTH)-1];
	bus_data_t		wkram_model [bus_addr_t];
	bus_addr_t		rom_used [$];
	bus_addr_t		wkram_used [$];
	longint			cycle_count = 0;
	longint			clear_cycle = 0;
	logic			latch_model = 1'b0;

	aznable_bus aznable_bus_inst (
		.clk_24		(clk_24),
		.reset		(reset),
		.wb_req		(wb_req),
		.ack		(ack),
		.dat_r		(dat_r),
		.download	(download),
		.inputs		(inputs),
		.pause		(pause)
	);

	initial clk_24 = 1'b0;
	always #10 clk_24 = ~clk_24;

	always @(posedge clk_24)
		cycle_count++;

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0]	v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Reference byte lane, bits past the vector width read 0
	function automatic bus_data_t expected_byte(input logic [255:0] vec, input int width,
		input int idx);
		bus_data_t	b;
		int			pos;
		b = '0;
		for (int k = 0; k < 8; k++)
		begin
			pos = idx * 8 + k;
			if (pos < width)
				b[k] = vec[pos];
		end
		return b;
	endfunction

	task automatic start_request(input logic we, input bus_addr_t adr, input bus_data_t dat);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat_w = dat;
	endtask

	// Polls ack after each edge, releases the request once it is seen
	task automatic wait_ack(input int limit, output bus_data_t data, output bit got);
		got = 1'b0;
		data = '0;
		for (int n = 0; n < limit && !got; n++)
		begin
			@(posedge clk_24);
			#1;
			if (ack)
			begin
				got = 1'b1;
				data = dat_r;
			end
		end
		if (got)
		begin
			wb_req.cyc = 1'b0;
			wb_req.stb = 1'b0;
		end
	endtask

	task automatic bus_transfer(input logic we, input bus_addr_t adr, input bus_data_t dat,
		output bus_data_t data);
		bit	got;
		start_request(we, adr, dat);
		wait_ack(2000, data, got);
		if (!got)
		begin
			report_failure($sformatf("no ack within 2000 cycles at address %h", adr));
			wb_req.cyc = 1'b0;
			wb_req.stb = 1'b0;
		end
	endtask

	task automatic send_download(input logic [7:0] index, input dn_addr_t addr,
		input bus_data_t data);
		download.wr = 1'b1;
		download.index = index;
		download.addr = addr;
		download.data = data;
		@(posedge clk_24);
		#1;
		download.wr = 1'b0;
	endtask

	task automatic read_page(input string name, input logic [7:0] page,
		input logic [255:0] vec, input int width);
		bus_data_t	data;
		int			nbytes;
		nbytes = (width + 7) / 8;
		for (int idx = 0; idx < nbytes + 3; idx++)
		begin
			bus_transfer(1'b0, {page, 8'(idx)}, 8'h00, data);
			check_data($sformatf("%s byte %0d", name, idx), expected_byte(vec, width, idx), data);
		end
		bus_transfer(1'b0, {page, 8'hff}, 8'h00, data);
		check_data($sformatf("%s byte 255", name), expected_byte(vec, width, 255), data);
	endtask

	initial
	begin
		bus_data_t		data;
		bus_data_t		lo;
		bus_data_t		hi;
		bus_addr_t		adr;
		bit				got;
		player_inputs_t	rnd_inputs;
		bus_addr_t		unmapped [5];

		wb_req = '0;
		download = '0;
		inputs = '0;
		pause = 1'b0;
		reset = 1'b1;
		repeat (2) @(posedge clk_24);
		#1;
		reset = 1'b0;

		// ROM download, other indices must not land in the program ROM
		for (int i = 0; i < 64; i++)
		begin
			adr = {1'b0, 15'(rand_bits(15))};
			data = 8'(rand_bits(8));
			rom_model[adr[14:0]] = data;
			rom_used.push_back(adr);
			send_download(`DN_INDEX_PGROM, {2'b00, adr[14:0]}, data);
			send_download(8'(1 + rand_bits(2)), {2'b00, adr[14:0]}, ~data);
		end
		for (int i = 0; i < 16; i++)
			bus_transfer(1'b1, rom_used[i], 8'(rand_bits(8)), data);
		foreach (rom_used[i])
		begin
			bus_transfer(1'b0, rom_used[i], 8'h00, data);
			check_data($sformatf("rom %h", rom_used[i]), rom_model[rom_used[i][14:0]], data);
		end

		// Work RAM writes, each followed by a read of an earlier address
		for (int i = 0; i < 100; i++)
		begin
			adr = {2'b11, 14'(rand_bits(14))};
			data = 8'(rand_bits(8));
			wkram_model[adr] = data;
			wkram_used.push_back(adr);
			bus_transfer(1'b1, adr, data, lo);
			adr = wkram_used[rand_bits(16) % wkram_used.size()];
			bus_transfer(1'b0, adr, 8'h00, data);
			check_data($sformatf("wkram %h", adr), wkram_model[adr], data);
		end

		// Input pages
		rnd_inputs.timestamp = {1'(rand_bits(1)), rand_bits(32)};
		rnd_inputs.ps2_key = 11'(rand_bits(11));
		rnd_inputs.paddle = {16'(rand_bits(16)), rand_bits(32)};
		for (int w = 0; w < 6; w++)
			rnd_inputs.joystick[w*32 +: 32] = rand_bits(32);
		inputs = rnd_inputs;
		read_page("joystick", `PAGE_JOYSTICK, 256'(rnd_inputs.joystick), 192);
		read_page("paddle", `PAGE_PADDLE, 256'(rnd_inputs.paddle), 48);
		read_page("ps2_key", `PAGE_PS2_KEY, 256'(rnd_inputs.ps2_key), 11);
		read_page("timestamp", `PAGE_TIMESTAMP, 256'(rnd_inputs.timestamp), 33);
		unmapped = '{16'h8000, 16'h8255, 16'h8A00, 16'h8C10, 16'hBFFF};
		foreach (unmapped[i])
		begin
			adr = unmapped[i];
			bus_transfer(1'b0, adr, 8'h00, data);
			check_data($sformatf("unmapped %h", adr), 8'h00, data);
		end

		// Let the count run past 2 ms so the clear has something to zero
		repeat (2 * `CYCLES_PER_MS) @(posedge clk_24);
		#1;

		// Timer, cleared by a write to its page
		bus_transfer(1'b1, {`PAGE_TIMER, 8'h00}, 8'h5a, data);
		clear_cycle = cycle_count;
		bus_transfer(1'b0, {`PAGE_TIMER, 8'h00}, 8'h00, lo);
		check_data("timer low after clear", 8'((cycle_count - clear_cycle) / `CYCLES_PER_MS), lo);
		repeat (3 * `CYCLES_PER_MS + 100) @(posedge clk_24);
		#1;
		bus_transfer(1'b0, {`PAGE_TIMER, 8'h00}, 8'h00, lo);
		bus_transfer(1'b0, {`PAGE_TIMER, 8'h01}, 8'h00, hi);
		check_timer("timer after 3 ms", 16'((cycle_count - clear_cycle) / `CYCLES_PER_MS),
			{hi, lo});
		bus_transfer(1'b0, {`PAGE_TIMER, 8'h02}, 8'h00, data);
		check_data("timer byte 2", 8'h00, data);

		// Software pause, released by a one-cycle external pause
		adr = wkram_used[0];
		bus_transfer(1'b1, 16'h8A37, 8'h01, data);
		latch_model = 1'b1;
		start_request(1'b0, adr, 8'h00);
		wait_ack(200, data, got);
		if (got == latch_model)
			report_failure("read acknowledged while the pause latch was set");
		pause = 1'b1;
		@(posedge clk_24);
		#1;
		pause = 1'b0;
		latch_model = 1'b0;
		wait_ack(2000, data, got);
		if (!got)
			report_failure("read not acknowledged after the pause latch was released");
		else
			check_data("read after pause latch", wkram_model[adr], data);

		// External pause held alone
		pause = 1'b1;
		start_request(1'b0, adr, 8'h00);
		wait_ack(200, data, got);
		if (got)
			report_failure("read acknowledged while external pause was high");
		pause = 1'b0;
		wait_ack(2000, data, got);
		if (!got)
			report_failure("read not acknowledged after external pause dropped");
		else
			check_data("read after external pause", wkram_model[adr], data);

		print_summary();
		if (fail_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== logic/aznable_bus.sv ====
`timescale 1ns/1ps

module aznable_bus (
	input	logic							clk_24,
	input	logic							reset,
	input	aznable_pkg::wb_req_t			wb_req,
	output	logic							ack,
	output	aznable_pkg::bus_data_t			dat_r,
	input	aznable_pkg::download_t			download,
	input	aznable_pkg::player_inputs_t	inputs,
	input	logic							pause
);
	import aznable_pkg::*;

	page_sel_t	page_sel;
	logic		pause_wr;
	logic		pause_system;
	logic		timer_clear;
	logic		wkram_we;
	timer_t		timer;
	bus_data_t	port_data;
	bus_data_t	rom_data;
	bus_data_t	wkram_data;

	// Wishbone slave, address decode and read mux
	bus_decoder bus_decoder_inst (
		.clk_24			(clk_24),
		.reset			(reset),
		.wb_req			(wb_req),
		.pause_system	(pause_system),
		.ack			(ack),
		.dat_r			(dat_r),
		.page_sel		(page_sel),
		.pause_wr		(pause_wr),
		.timer_clear	(timer_clear),
		.wkram_we		(wkram_we),
		.port_data		(port_data),
		.rom_data		(rom_data),
		.wkram_data		(wkram_data)
	);

	// Pause latch, stalls the decoder
	system_control system_control_inst (
		.clk_24			(clk_24),
		.reset			(reset),
		.pause			(pause),
		.pause_wr		(pause_wr),
		.pause_system	(pause_system)
	);

	ms_timer ms_timer_inst (
		.clk_24			(clk_24),
		.reset			(reset),
		.clear			(timer_clear),
		.count			(timer)
	);

	// Byte lane picked by the low address byte
	input_ports input_ports_inst (
		.inputs			(inputs),
		.timer			(timer),
		.page_sel		(page_sel),
		.byte_index		(wb_req.adr[7:0]),
		.port_data		(port_data)
	);

	// Program ROM and work RAM
	memory_block memory_block_inst (
		.clk_24			(clk_24),
		.adr			(wb_req.adr),
		.dat_w			(wb_req.dat_w),
		.wkram_we		(wkram_we),
		.download		(download),
		.rom_data		(rom_data),
		.wkram_data		(wkram_data)
	);

endmodule

// ==== logic/memory_block.sv ====
`timescale 1ns/1ps
`include "aznable_settings.svh"

module memory_block (
	input	logic					clk_24,
	input	aznable_pkg::bus_addr_t	adr,
	input	aznable_pkg::bus_data_t	dat_w,
	input	logic					wkram_we,
	input	aznable_pkg::download_t	download,
	output	aznable_pkg::bus_data_t	rom_data,
	output	aznable_pkg::bus_data_t	wkram_data
);
	import aznable_pkg::*;

	localparam int rom_depth = 1 << `ROM_WIDTH;
	localparam int wkram_depth = 1 << `WKRAM_WIDTH;

	bus_data_t		pgrom [0:rom_depth-1];
	bus_data_t		wkram [0:wkram_depth-1];
	rom_addr_t		rom_rd_addr;
	rom_addr_t		rom_wr_addr;
	wkram_addr_t	wkram_addr;
	logic			pgrom_we;

	assign rom_rd_addr = adr[`ROM_WIDTH-1:0];
	assign rom_wr_addr = download.addr[`ROM_WIDTH-1:0];
	assign wkram_addr = adr[`WKRAM_WIDTH-1:0];

	// Only the program ROM index is loaded here
	assign pgrom_we = download.wr && download.index == `DN_INDEX_PGROM;

	// Program ROM, bus read port
	always_ff @(posedge clk_24)
	begin
		rom_data <= pgrom[rom_rd_addr];
	end

	// Program ROM, download write port
	always_ff @(posedge clk_24)
	begin
		if (pgrom_we)
			pgrom[rom_wr_addr] <= download.data;
	end

	// Work RAM, single port. A read in the write cycle returns the old byte
	always_ff @(posedge clk_24)
	begin
		if (wkram_we)
			wkram[wkram_addr] <= dat_w;
		wkram_data <= wkram[wkram_addr];
	end

endmodule

// ==== logic/input_ports.sv ====
`timescale 1ns/1ps

module input_ports (
	input	aznable_pkg::player_inputs_t	inputs,
	input	aznable_pkg::timer_t			timer,
	input	aznable_pkg::page_sel_t			page_sel,
	input	aznable_pkg::bus_data_t			byte_index,
	output	aznable_pkg::bus_data_t			port_data
);
	import aznable_pkg::*;

	// Readable bytes per page, partial top bytes are zero-padded
	localparam int joystick_bytes = ($bits(inputs.joystick) + 7) / 8;
	localparam int paddle_bytes = ($bits(inputs.paddle) + 7) / 8;
	localparam int ps2_key_bytes = ($bits(inputs.ps2_key) + 7) / 8;
	localparam int timestamp_bytes = ($bits(inputs.timestamp) + 7) / 8;
	localparam int timer_bytes = ($bits(timer) + 7) / 8;

	// Byte idx of vec, or 0 past the last byte
	function automatic bus_data_t pick_byte(
		input logic [255:0]	vec,
		input int			nbytes,
		input bus_data_t	idx
	);
		bus_data_t	picked;
		picked = vec[{idx[4:0], 3'b000} +: 8];
		if (idx >= nbytes)
			picked = 8'h00;
		return picked;
	endfunction

	always_comb
	begin
		port_data = 8'h00;
		if (page_sel.joystick)
		begin
			port_data = pick_byte(256'(inputs.joystick), joystick_bytes, byte_index);
		end
		else if (page_sel.paddle)
		begin
			port_data = pick_byte(256'(inputs.paddle), paddle_bytes, byte_index);
		end
		else if (page_sel.ps2_key)
		begin
			port_data = pick_byte(256'(inputs.ps2_key), ps2_key_bytes, byte_index);
		end
		else if (page_sel.timestamp)
		begin
			port_data = pick_byte(256'(inputs.timestamp), timestamp_bytes, byte_index);
		end
		else if (page_sel.timer)
		begin
			port_data = pick_byte(256'(timer), timer_bytes, byte_index);
		end
	end

endmodule

// ==== logic/ms_timer.sv ====
`timescale 1ns/1ps
`include "aznable_settings.svh"

module ms_timer #(
	parameter int cycles_per_ms = `CYCLES_PER_MS
) (
	input	logic					clk_24,
	input	logic					reset,
	input	logic					clear,
	output	aznable_pkg::timer_t	count
);

	localparam int prescale_width = $clog2(cycles_per_ms);

	logic [prescale_width-1:0]	prescale;
	logic						ms_tick;

	assign ms_tick = prescale == prescale_width'(cycles_per_ms - 1);

	always_ff @(posedge clk_24)
	begin
		if (reset || clear)
		begin
			prescale <= '0;
			count <= '0;
		end
		else if (ms_tick)
		begin
			prescale <= '0;
			// Count wraps at 16 bits
			count <= count + 1'b1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

// ==== logic/system_control.sv ====
`timescale 1ns/1ps

module system_control (
	input	logic	clk_24,
	input	logic	reset,
	input	logic	pause,
	input	logic	pause_wr,
	output	logic	pause_system
);

	logic	pause_latch;

	// Software pause, set by a bus write and released by the external pause
	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			pause_latch <= 1'b0;
		end
		else if (pause)
		begin
			// External pause wins over a write in the same cycle
			pause_latch <= 1'b0;
		end
		else if (pause_wr)
		begin
			pause_latch <= 1'b1;
		end
	end

	// Either source stalls the bus
	assign pause_system = pause | pause_latch;

	latch_released: assert property (@(posedge clk_24) disable iff (reset)
		pause |=> !pause_latch);

endmodule

// ==== logic/bus_decoder.sv ====
`timescale 1ns/1ps
`include "aznable_settings.svh"

module bus_decoder (
	input	logic					clk_24,
	input	logic					reset,
	input	aznable_pkg::wb_req_t	wb_req,
	input	logic					pause_system,
	output	logic					ack,
	output	aznable_pkg::bus_data_t	dat_r,
	output	aznable_pkg::page_sel_t	page_sel,
	output	logic					pause_wr,
	output	logic					timer_clear,
	output	logic					wkram_we,
	input	aznable_pkg::bus_data_t	port_data,
	input	aznable_pkg::bus_data_t	rom_data,
	input	aznable_pkg::bus_data_t	wkram_data
);
	import aznable_pkg::*;

	bus_state_t	state;
	page_sel_t	sel_q;
	bus_data_t	read_byte;
	logic [7:0]	page;
	logic		pause_cs;
	logic		port_hit;
	logic		accept;
	logic		write_acc;

	// Address decode
	assign page = wb_req.adr[15:8];
	always_comb
	begin
		page_sel.rom = ~wb_req.adr[15];
		page_sel.wkram = wb_req.adr[15:14] == 2'b11;
		page_sel.joystick = page == `PAGE_JOYSTICK;
		page_sel.paddle = page == `PAGE_PADDLE;
		page_sel.ps2_key = page == `PAGE_PS2_KEY;
		page_sel.timestamp = page == `PAGE_TIMESTAMP;
		page_sel.timer = page == `PAGE_TIMER;
	end
	assign pause_cs = wb_req.adr[15:4] == `PAUSE_BLOCK;

	// Ack still high means the master has not yet dropped stb
	assign accept = wb_req.cyc && wb_req.stb && state == BUS_IDLE && !ack && !pause_system;

	// Write strobes, acceptance cycle only. ROM is not writable from the bus
	assign write_acc = accept && wb_req.we;
	assign pause_wr = write_acc && pause_cs;
	assign timer_clear = write_acc && page_sel.timer;
	assign wkram_we = write_acc && page_sel.wkram;

	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			state <= BUS_IDLE;
			ack <= 1'b0;
		end
		else
		begin
			ack <= 1'b0;
			case (state)
				BUS_IDLE:
				begin
					if (accept)
						state <= BUS_ACK;
				end
				BUS_ACK:
				begin
					ack <= 1'b1;
					state <= BUS_IDLE;
				end
				default:
				begin
					state <= BUS_IDLE;
				end
			endcase
		end
	end

	// Read mux, unmapped addresses give 0
	assign port_hit = sel_q.joystick | sel_q.paddle | sel_q.ps2_key |
		sel_q.timestamp | sel_q.timer;
	assign read_byte = sel_q.rom ? rom_data :
		sel_q.wkram ? wkram_data :
		port_hit ? port_data :
		8'h00;

	always_ff @(posedge clk_24)
	begin
		if (accept)
			sel_q <= page_sel;
		if (state == BUS_ACK)
			dat_r <= read_byte;
	end

	ack_single_pulse: assert property (@(posedge clk_24) disable iff (reset)
		ack |=> !ack);

	// A stalled bus never leaves idle
	stall_holds_idle: assert property (@(posedge clk_24) disable iff (reset)
		(state == BUS_IDLE && pause_system) |=> state == BUS_IDLE);

endmodule

// ==== logic/aznable_pkg.sv ====
`include "aznable_settings.svh"

package aznable_pkg;

	// Plain vectors with a meaning
	typedef logic [15:0]				bus_addr_t;
	typedef logic [7:0]					bus_data_t;
	typedef logic [`ROM_WIDTH-1:0]		rom_addr_t;
	typedef logic [`WKRAM_WIDTH-1:0]	wkram_addr_t;
	typedef logic [16:0]				dn_addr_t;
	typedef logic [15:0]				timer_t;

	// Wishbone classic request from the master
	typedef struct packed {
		logic		cyc;
		logic		stb;
		logic		we;
		bus_addr_t	adr;
		bus_data_t	dat_w;
	} wb_req_t;

	// ROM download stream, one byte per cycle with wr high
	typedef struct packed {
		logic		wr;
		logic [7:0]	index;
		dn_addr_t	addr;
		bus_data_t	data;
	} download_t;

	// Player inputs, least significant byte at byte index 0
	typedef struct packed {
		logic [191:0]	joystick;
		logic [47:0]	paddle;
		logic [10:0]	ps2_key;
		logic [32:0]	timestamp;
	} player_inputs_t;

	// One select per readable target
	typedef struct packed {
		logic	rom;
		logic	wkram;
		logic	joystick;
		logic	paddle;
		logic	ps2_key;
		logic	timestamp;
		logic	timer;
	} page_sel_t;

	typedef enum logic [0:0] {
		BUS_IDLE = 1'b0,
		BUS_ACK  = 1'b1
	} bus_state_t;

endpackage

// ==== logic/aznable_settings.svh ====
`ifndef AZNABLE_SETTINGS_SVH
`define AZNABLE_SETTINGS_SVH

// Memory-mapped input pages, selected by address bits [15:8]
`define PAGE_JOYSTICK		8'h81
`define PAGE_PADDLE			8'h84
`define PAGE_PS2_KEY		8'h86
`define PAGE_TIMESTAMP		8'h88

// Millisecond timer page, any write clears the count
`define PAGE_TIMER			8'h89

// System pause block 0x8A30 - 0x8A3F, selected by address bits [15:4]
`define PAUSE_BLOCK			12'h8A3

// Program ROM 0x0000 - 0x7FFF (32 KB)
`define ROM_WIDTH			15

// Work RAM 0xC000 - 0xFFFF (16 KB)
`define WKRAM_WIDTH			14

// Download index that targets the program ROM
`define DN_INDEX_PGROM		8'd0

// 24 MHz clock cycles in one millisecond
`define CYCLES_PER_MS		24000

`endif
